// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = cache_tb
FILES   = list.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILES) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/backend_memory.sv
`timescale 1ns/100ps

module backend_memory (
   input  logic                           clk_i,
   input  logic                           reset,
   input  logic                           be_valid,
   input  logic [cache_pkg::addr_w-1:0]   be_addr,
   input  logic [cache_pkg::data_w-1:0]   be_wdata,
   input  logic [cache_pkg::nbytes-1:0]   be_wstrb,
   output logic                           be_ack,
   output logic [cache_pkg::data_w-1:0]   be_rdata
);
   import cache_pkg::*;

   logic [data_w-1:0] mem [256];
   logic [31:0]       rng;
   logic [1:0]        wait_cnt;
   logic [7:0]        waddr;

   function automatic logic [31:0] step_rng(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   assign waddr = be_addr[9:2]; // 256 words

   initial begin
      for (int i = 0; i < 256; i++) begin
         logic [7:0] w;
         w = 8'(i);
         mem[i] = {w ^ 8'h5a, ~w, w + 8'h21, w[3:0], w[7:4]};
      end
   end

   always @(posedge clk_i, posedge reset) begin
      if (reset) begin
         be_ack   <= 1'b0;
         be_rdata <= '0;
         wait_cnt <= '0;
         rng      <= 32'd27;
      end else if (be_ack) begin
         be_ack <= 1'b0; // one ack per transfer
      end else if (be_valid) begin
         if (wait_cnt == 2'd0) begin
            be_ack   <= 1'b1;
            be_rdata <= mem[waddr];
            for (int b = 0; b < nbytes; b++)
               if (be_wstrb[b]) mem[waddr][b*8 +: 8] <= be_wdata[b*8 +: 8];
            rng      <= step_rng(rng);
            wait_cnt <= rng[1:0]; // delay of the next transfer
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

endmodule

// File: bench/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
   import cache_pkg::*;

   typedef logic [data_w-1:0] word_t;
   typedef logic [addr_w-1:0] baddr_t;

   logic              clk_i, reset, valid, ready, be_valid, be_ack;
   baddr_t            addr, be_addr;
   word_t             wdata, rdata, be_wdata, be_rdata;
   logic [nbytes-1:0] wstrb, be_wstrb;

   baddr_t            log_addr[$];
   word_t             log_data[$];
   logic [nbytes-1:0] log_strb[$];
   word_t             exp_q[$];
   int                acked_writes = 0;
   logic [word_offset_w-1:0] fill_cnt = '0;
   logic [31:0]       rng = 32'd27;

   cache_top UUT (
      .clk_i, .reset, .valid, .addr, .wdata, .wstrb, .ready, .rdata, .be_valid, .be_addr,
      .be_wdata, .be_wstrb, .be_ack, .be_rdata
   );

   backend_memory u_backend (
      .clk_i, .reset, .be_valid, .be_addr, .be_wdata, .be_wstrb, .be_ack, .be_rdata
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic word_t initial_word(input logic [7:0] w);
      return {w ^ 8'h5a, ~w, w + 8'h21, w[3:0], w[7:4]};
   endfunction

   // replay every logged write to this word over the initial pattern
   function automatic word_t expected_word(input baddr_t a);
      word_t w;
      w = initial_word(a[9:2]);
      foreach (log_addr[i])
         if (log_addr[i][9:2] == a[9:2])
            for (int b = 0; b < nbytes; b++)
               if (log_strb[i][b]) w[b*8 +: 8] = log_data[i][b*8 +: 8];
      return w;
   endfunction

   task automatic fail(input string why);
      $display("ERROR at %0t: %s", $time, why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic compare_addr(input string name, input baddr_t got, input baddr_t exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic compare_strb(input string name, input logic [nbytes-1:0] got,
                               input logic [nbytes-1:0] exp);
      if (got !== exp) begin
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   task automatic issue(input baddr_t a, input word_t d, input logic [nbytes-1:0] s);
      int cycles;
      cycles = 0;
      if (s == '0) begin
         exp_q.push_back(expected_word(a));
      end else begin
         log_addr.push_back(a);
         log_data.push_back(d);
         log_strb.push_back(s);
      end
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      do begin
         @(posedge clk_i);
         cycles++;
         if (cycles > 200) fail("no ready within 200 cycles of a request");
      end while (!ready);
   endtask

   // responses and back-end traffic sampled mid-cycle
   always @(negedge clk_i) begin
      if (!reset) begin
         if (ready && wstrb == '0) begin
            if (exp_q.size() == 0) fail("read response with no read pending");
            else if (fill_cnt != '0) fail("line fill ended before its fourth word");
            else compare_word("rdata", rdata, exp_q.pop_front());
         end
         if (be_ack && be_wstrb == '0) begin
            if (acked_writes != log_addr.size()) begin
               fail("line read started with writes buffered");
            end else begin
               compare_addr("be_addr", be_addr,
                  {addr[addr_w-1:nbytes_w+word_offset_w], fill_cnt, {nbytes_w{1'b0}}});
               fill_cnt = fill_cnt + 2'd1;
            end
         end else if (be_ack) begin
            if (acked_writes >= log_addr.size()) begin
               fail("back-end write that was never requested");
            end else begin
               compare_addr("be_addr", be_addr, log_addr[acked_writes]);
               compare_word("be_wdata", be_wdata, log_data[acked_writes]);
               compare_strb("be_wstrb", be_wstrb, log_strb[acked_writes]);
               acked_writes++;
            end
         end
      end
   end

   initial begin
      logic [31:0] r;
      baddr_t      a;
      int          cycles;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      reset = 1'b1;
      repeat (10) @(posedge clk_i);
      reset <= 1'b0;
      repeat (4) begin
         @(negedge clk_i);
         if (ready || be_valid) fail("ready or be_valid active before any request");
      end
      @(posedge clk_i);

      issue(16'h0000, '0, '0); // untouched word
      issue(16'h0010, 32'hcafe_f00d, 4'hf);
      issue(16'h0010, '0, '0); // miss after write
      issue(16'h0014, 32'h1234_5678, 4'hf); // line now present
      issue(16'h0014, '0, '0);
      issue(16'h0018, 32'haabb_ccdd, 4'b0101);
      issue(16'h0018, '0, '0);
      issue(16'h001c, 32'h9988_7766, 4'b1000);
      issue(16'h001c, '0, '0);

      // burst deeper than the buffer
      for (int i = 0; i < 12; i++) begin
         rng = xorshift(rng);
         issue(baddr_t'(32'h200 + 4 * i), rng, 4'hf);
      end
      issue(16'h0204, '0, '0);

      // two tags fighting over index 5
      for (int i = 0; i < 8; i++) begin
         a = {6'd0, i[0] ? 2'd2 : 2'd0, 4'd5, 2'(i), 2'b00};
         issue(a, '0, '0);
         if (i == 3) begin
            rng = xorshift(rng);
            issue(a, rng, 4'b0011);
         end
      end

      for (int n = 0; n < 300; n++) begin
         rng = xorshift(rng);
         r   = rng;
         rng = xorshift(rng);
         a   = {6'd0, r[9:2], 2'b00};
         if (r[12:10] < 3'd5) issue(a, rng, r[16:13] == 4'h0 ? 4'hf : r[16:13]);
         else issue(a, rng, '0);
      end
      valid <= 1'b0;

      cycles = 0;
      while (acked_writes != log_addr.size()) begin
         @(posedge clk_i);
         cycles++;
         if (cycles > 500) fail("write buffer did not drain");
      end
      for (int i = 0; i < 256; i++)
         compare_word("backend memory word", u_backend.mem[i], expected_word(baddr_t'(i * 4)));

      if (exp_q.size() != 0) begin
         fail("reads left without a response");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

// File: list.f
logic/cache_pkg.sv
logic/cache_memory.sv
logic/write_buffer.sv
logic/write_channel.sv
logic/read_channel.sv
logic/backend_arbiter.sv
logic/cache_control.sv
logic/cache_top.sv
bench/backend_memory.sv
bench/cache_tb.sv

// File: logic/backend_arbiter.sv
`timescale 1ns/100ps

module backend_arbiter (
   input  logic                            clk_i,
   input  logic                            reset,
   input  logic                            wr_req,
   input  logic [cache_pkg::addr_w-1:0]    wr_addr,
   input  logic [cache_pkg::data_w-1:0]    wr_wdata,
   input  logic [cache_pkg::nbytes-1:0]    wr_wstrb,
   input  logic                            rd_req,
   input  logic [cache_pkg::addr_w-1:0]    rd_addr,
   input  logic                            be_ack,
   output logic                            wr_ack,
   output logic                            rd_ack,
   output logic                            be_valid,
   output logic [cache_pkg::addr_w-1:0]    be_addr,
   output logic [cache_pkg::data_w-1:0]    be_wdata,
   output logic [cache_pkg::nbytes-1:0]    be_wstrb
);
   logic locked, lock_wr;
   logic sel_wr, sel_req;

   assign sel_wr  = locked ? lock_wr : wr_req; // write side wins a tie
   assign sel_req = sel_wr ? wr_req : rd_req;

   assign be_valid = sel_req & ~be_ack;
   assign be_addr  = sel_wr ? wr_addr : rd_addr;
   assign be_wdata = wr_wdata;
   assign be_wstrb = sel_wr ? wr_wstrb : '0; // zero strobe is a read
   assign wr_ack   = be_ack & sel_wr;
   assign rd_ack   = be_ack & ~sel_wr;

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         locked  <= 1'b0;
         lock_wr <= 1'b0;
      end else if (be_ack) begin
         locked <= 1'b0;
      end else if (sel_req & ~locked) begin
         locked  <= 1'b1;
         lock_wr <= sel_wr;
      end
   end

   // every ack goes back to a channel still holding its request
   ack_to_requester: assert property (@(posedge clk_i) disable iff (reset)
      be_ack |-> (wr_ack ? wr_req : rd_req));

endmodule

// File: logic/cache_control.sv
`timescale 1ns/100ps

module cache_control (
   input  logic                              clk_i,
   input  logic                              reset,
   input  logic                              valid,
   input  logic [cache_pkg::addr_w-1:0]      addr,
   input  logic [cache_pkg::data_w-1:0]      wdata,
   input  logic [cache_pkg::nbytes-1:0]      wstrb,
   input  logic                              hit,
   input  logic [cache_pkg::data_w-1:0]      hit_data,
   input  logic                              wbuf_full,
   input  logic                              wbuf_empty,
   input  logic                              fill_done,
   output logic                              ready,
   output logic [cache_pkg::data_w-1:0]      rdata,
   output logic                              lookup_en,
   output logic [cache_pkg::index_w-1:0]     lookup_index,
   output logic                              upd_we,
   output logic [cache_pkg::nbytes-1:0]      upd_strb,
   output logic [cache_pkg::data_w-1:0]      upd_data,
   output logic                              wbuf_push,
   output logic [cache_pkg::addr_w-1:0]      wbuf_addr,
   output logic [cache_pkg::data_w-1:0]      wbuf_wdata,
   output logic [cache_pkg::nbytes-1:0]      wbuf_wstrb,
   output logic                              fill_start,
   output logic [cache_pkg::addr_w-1:0]      fill_addr
);
   import cache_pkg::*;

   ctrl_state_t state, state_nxt;
   logic        is_write;
   logic        respond;

   assign is_write = |wstrb;

   // requester holds these fields until ready
   assign lookup_index = addr[nbytes_w+word_offset_w +: index_w];
   assign upd_strb     = wstrb;
   assign upd_data     = wdata;
   assign wbuf_addr    = addr;
   assign wbuf_wdata   = wdata;
   assign wbuf_wstrb   = wstrb;
   assign fill_addr    = {addr[addr_w-1:nbytes_w+word_offset_w], {(nbytes_w+word_offset_w){1'b0}}};
   assign rdata        = hit_data; // memory output holds until the next lookup

   always_comb begin
      state_nxt  = state;
      lookup_en  = 1'b0;
      upd_we     = 1'b0;
      wbuf_push  = 1'b0;
      fill_start = 1'b0;
      respond    = 1'b0;

      case (state)
         ctrl_idle: begin
            lookup_en = valid & ~ready; // ignore the request just answered
            if (valid & ~ready) state_nxt = ctrl_lookup;
         end
         ctrl_lookup: begin
            if (is_write) begin
               if (~wbuf_full) begin
                  wbuf_push = 1'b1;
                  upd_we    = hit;
                  respond   = 1'b1;
                  state_nxt = ctrl_idle;
               end
            end else if (hit) begin
               respond   = 1'b1;
               state_nxt = ctrl_idle;
            end else begin
               state_nxt = ctrl_drain;
            end
         end
         ctrl_drain: begin
            fill_start = wbuf_empty;
            if (wbuf_empty) state_nxt = ctrl_fill;
         end
         ctrl_fill: begin
            if (fill_done) state_nxt = ctrl_fill_done;
         end
         default: begin // look the filled line up again
            lookup_en = 1'b1;
            state_nxt = ctrl_lookup;
         end
      endcase
   end

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         state <= ctrl_idle;
         ready <= 1'b0;
      end else begin
         state <= state_nxt;
         ready <= respond;
      end
   end

   // requester keeps its request steady until ready
   request_held: assert property (@(posedge clk_i) disable iff (reset)
      valid & ~ready |=> valid & $stable(addr) & $stable(wdata) & $stable(wstrb));

endmodule

// File: logic/cache_memory.sv
`timescale 1ns/100ps

module cache_memory (
   input  logic                                clk_i,
   input  logic                                reset,
   input  logic                                lookup_en,
   input  logic [cache_pkg::index_w-1:0]       lookup_index,
   input  logic [cache_pkg::addr_w-1:0]        lookup_addr,
   input  logic                                upd_we,
   input  logic [cache_pkg::nbytes-1:0]        upd_strb,
   input  logic [cache_pkg::data_w-1:0]        upd_data,
   input  logic                                fill_we,
   input  logic [cache_pkg::index_w-1:0]       fill_index,
   input  logic [cache_pkg::word_offset_w-1:0] fill_word,
   input  logic [cache_pkg::data_w-1:0]        fill_data,
   input  logic [cache_pkg::tag_w-1:0]         fill_tag,
   output logic                                hit,
   output logic [cache_pkg::data_w-1:0]        hit_data
);
   import cache_pkg::*;

   logic [tag_w-1:0]  tag_mem  [2**index_w];
   logic [data_w-1:0] data_mem [2**(index_w+word_offset_w)];
   logic [2**index_w-1:0] valid_bits;

   logic [tag_w-1:0]  tag_q;
   logic              valid_q;
   logic [index_w+word_offset_w-1:0] upd_word_addr;
   logic [word_offset_w-1:0]         lookup_word;

   assign upd_word_addr = lookup_addr[nbytes_w +: index_w+word_offset_w];
   assign lookup_word   = lookup_addr[nbytes_w +: word_offset_w];

   assign hit = valid_q & (tag_q == lookup_addr[addr_w-1 -: tag_w]);

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         valid_bits <= '0;
         valid_q    <= 1'b0;
      end else begin
         if (fill_we & (&fill_word)) valid_bits[fill_index] <= 1'b1; // line complete
         if (lookup_en) valid_q <= valid_bits[lookup_index];
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_en) begin
         tag_q    <= tag_mem[lookup_index];
         hit_data <= data_mem[{lookup_index, lookup_word}];
      end
      if (fill_we) begin
         data_mem[{fill_index, fill_word}] <= fill_data;
         if (&fill_word) tag_mem[fill_index] <= fill_tag;
      end else if (upd_we) begin
         for (int b = 0; b < nbytes; b++)
            if (upd_strb[b]) data_mem[upd_word_addr][b*8 +: 8] <= upd_data[b*8 +: 8];
      end
   end

   // controller never updates while the read channel is filling
   no_dual_write: assert property (@(posedge clk_i) disable iff (reset)
      !(upd_we && fill_we));

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

   // address and word geometry
   localparam int addr_w        = 16;
   localparam int data_w        = 32;
   localparam int nbytes        = data_w / 8;
   localparam int nbytes_w      = 2;
   localparam int word_offset_w = 2; // four words per line
   localparam int index_w       = 4; // 16 lines
   localparam int tag_w         = addr_w - index_w - word_offset_w - nbytes_w;

   localparam int wbuf_depth_w  = 2; // four pending writes

   // shared by the write and read channels
   typedef enum logic [0:0] {
      ch_idle,
      ch_xfer
   } channel_state_t;

   typedef enum logic [2:0] {
      ctrl_idle,
      ctrl_lookup,
      ctrl_drain,     // wait for buffered writes to leave
      ctrl_fill,
      ctrl_fill_done  // re-read the filled line
   } ctrl_state_t;

endpackage

// File: logic/cache_top.sv
`timescale 1ns/100ps

module cache_top (
   input  logic                           clk_i,
   input  logic                           reset,
   input  logic                           valid,
   input  logic [cache_pkg::addr_w-1:0]   addr,
   input  logic [cache_pkg::data_w-1:0]   wdata,
   input  logic [cache_pkg::nbytes-1:0]   wstrb,
   output logic                           ready,
   output logic [cache_pkg::data_w-1:0]   rdata,
   output logic                           be_valid,
   output logic [cache_pkg::addr_w-1:0]   be_addr,
   output logic [cache_pkg::data_w-1:0]   be_wdata,
   output logic [cache_pkg::nbytes-1:0]   be_wstrb,
   input  logic                           be_ack,
   input  logic [cache_pkg::data_w-1:0]   be_rdata
);
   import cache_pkg::*;

   logic lookup_en, upd_we, hit, wbuf_push, wbuf_full, wbuf_empty, wbuf_pop;
   logic fill_start, fill_done, fill_we, wr_req, wr_ack, rd_req, rd_ack;
   logic [index_w-1:0]       lookup_index, fill_index;
   logic [nbytes-1:0]        upd_strb, wbuf_wstrb, head_wstrb, wr_wstrb;
   logic [data_w-1:0]        upd_data, hit_data, wbuf_wdata, head_wdata, wr_wdata, fill_data;
   logic [addr_w-1:0]        wbuf_addr, head_addr, fill_addr, wr_addr, rd_addr;
   logic [word_offset_w-1:0] fill_word;
   logic [tag_w-1:0]         fill_tag;

   cache_control u_control (
      .clk_i, .reset, .valid, .addr, .wdata, .wstrb, .hit, .hit_data, .wbuf_full,
      .wbuf_empty, .fill_done, .ready, .rdata, .lookup_en, .lookup_index, .upd_we,
      .upd_strb, .upd_data, .wbuf_push, .wbuf_addr, .wbuf_wdata, .wbuf_wstrb,
      .fill_start, .fill_addr
   );

   cache_memory u_memory (
      .clk_i, .reset, .lookup_en, .lookup_index, .lookup_addr(addr), .upd_we, .upd_strb,
      .upd_data, .fill_we, .fill_index, .fill_word, .fill_data, .fill_tag, .hit, .hit_data
   );

   write_buffer u_wbuf (
      .clk_i, .reset, .push(wbuf_push), .in_addr(wbuf_addr), .in_wdata(wbuf_wdata),
      .in_wstrb(wbuf_wstrb), .pop(wbuf_pop), .full(wbuf_full), .empty(wbuf_empty),
      .head_addr, .head_wdata, .head_wstrb
   );

   write_channel u_write_ch (
      .clk_i, .reset, .wbuf_empty, .head_addr, .head_wdata, .head_wstrb, .ack(wr_ack),
      .wbuf_pop, .req(wr_req), .req_addr(wr_addr), .req_wdata(wr_wdata),
      .req_wstrb(wr_wstrb)
   );

   read_channel u_read_ch (
      .clk_i, .reset, .fill_start, .fill_addr, .ack(rd_ack), .be_rdata, .req(rd_req),
      .req_addr(rd_addr), .fill_we, .fill_index, .fill_word, .fill_data, .fill_tag,
      .fill_done
   );

   backend_arbiter u_arbiter (
      .clk_i, .reset, .wr_req, .wr_addr, .wr_wdata, .wr_wstrb, .rd_req, .rd_addr, .be_ack,
      .wr_ack, .rd_ack, .be_valid, .be_addr, .be_wdata, .be_wstrb
   );

endmodule

// File: logic/read_channel.sv
`timescale 1ns/100ps

module read_channel (
   input  logic                                clk_i,
   input  logic                                reset,
   input  logic                                fill_start,
   input  logic [cache_pkg::addr_w-1:0]        fill_addr,
   input  logic                                ack,
   input  logic [cache_pkg::data_w-1:0]        be_rdata,
   output logic                                req,
   output logic [cache_pkg::addr_w-1:0]        req_addr,
   output logic                                fill_we,
   output logic [cache_pkg::index_w-1:0]       fill_index,
   output logic [cache_pkg::word_offset_w-1:0] fill_word,
   output logic [cache_pkg::data_w-1:0]        fill_data,
   output logic [cache_pkg::tag_w-1:0]         fill_tag,
   output logic                                fill_done
);
   import cache_pkg::*;

   channel_state_t           state;
   logic [word_offset_w-1:0] word_cnt;
   logic [tag_w-1:0]         line_tag;
   logic [index_w-1:0]       line_index;

   assign req        = (state == ch_xfer);
   assign req_addr   = {line_tag, line_index, word_cnt, {nbytes_w{1'b0}}};
   assign fill_we    = req & ack;
   assign fill_index = line_index;
   assign fill_word  = word_cnt;
   assign fill_data  = be_rdata;
   assign fill_tag   = line_tag;

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         state     <= ch_idle;
         word_cnt  <= '0;
         fill_done <= 1'b0;
      end else begin
         fill_done <= 1'b0;
         case (state)
            ch_idle: begin
               word_cnt <= '0;
               if (fill_start) state <= ch_xfer;
            end
            default: begin
               if (ack) begin
                  word_cnt <= word_cnt + 1'b1;
                  if (&word_cnt) begin // last word of the line
                     state     <= ch_idle;
                     fill_done <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_start) begin
         line_tag   <= fill_addr[addr_w-1 -: tag_w];
         line_index <= fill_addr[nbytes_w+word_offset_w +: index_w];
      end
   end

endmodule

// File: logic/write_buffer.sv
`timescale 1ns/100ps

module write_buffer (
   input  logic                            clk_i,
   input  logic                            reset,
   input  logic                            push,
   input  logic [cache_pkg::addr_w-1:0]    in_addr,
   input  logic [cache_pkg::data_w-1:0]    in_wdata,
   input  logic [cache_pkg::nbytes-1:0]    in_wstrb,
   input  logic                            pop,
   output logic                            full,
   output logic                            empty,
   output logic [cache_pkg::addr_w-1:0]    head_addr,
   output logic [cache_pkg::data_w-1:0]    head_wdata,
   output logic [cache_pkg::nbytes-1:0]    head_wstrb
);
   import cache_pkg::*;

   logic [addr_w-1:0] addr_mem  [2**wbuf_depth_w];
   logic [data_w-1:0] wdata_mem [2**wbuf_depth_w];
   logic [nbytes-1:0] wstrb_mem [2**wbuf_depth_w];

   logic [wbuf_depth_w-1:0] wr_ptr, rd_ptr;
   logic [wbuf_depth_w:0]   count;

   assign full       = (count == (wbuf_depth_w+1)'(2**wbuf_depth_w));
   assign empty      = (count == '0);
   assign head_addr  = addr_mem[rd_ptr];
   assign head_wdata = wdata_mem[rd_ptr];
   assign head_wstrb = wstrb_mem[rd_ptr];

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1; // pointers wrap naturally
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + (wbuf_depth_w+1)'(push) - (wbuf_depth_w+1)'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_mem[wr_ptr]  <= in_addr;
         wdata_mem[wr_ptr] <= in_wdata;
         wstrb_mem[wr_ptr] <= in_wstrb;
      end
   end

   no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset) pop |-> !empty);
   no_push_when_full: assert property (@(posedge clk_i) disable iff (reset) push |-> !full);

endmodule

// File: logic/write_channel.sv
`timescale 1ns/100ps

module write_channel (
   input  logic                            clk_i,
   input  logic                            reset,
   input  logic                            wbuf_empty,
   input  logic [cache_pkg::addr_w-1:0]    head_addr,
   input  logic [cache_pkg::data_w-1:0]    head_wdata,
   input  logic [cache_pkg::nbytes-1:0]    head_wstrb,
   input  logic                            ack,
   output logic                            wbuf_pop,
   output logic                            req,
   output logic [cache_pkg::addr_w-1:0]    req_addr,
   output logic [cache_pkg::data_w-1:0]    req_wdata,
   output logic [cache_pkg::nbytes-1:0]    req_wstrb
);
   import cache_pkg::*;

   channel_state_t state;

   // word aligned, byte lanes come from the strobe
   assign req_addr  = {head_addr[addr_w-1:nbytes_w], {nbytes_w{1'b0}}};
   assign req_wdata = head_wdata;

   always_ff @(posedge clk_i, posedge reset) begin
      if (reset) begin
         state <= ch_idle;
      end else begin
         case (state)
            ch_idle: begin
               if (~wbuf_empty) state <= ch_xfer;
            end
            default: begin
               // stay while entries keep coming
               if (wbuf_empty) state <= ch_idle;
            end
         endcase
      end
   end

   always_comb begin
      req       = 1'b0;
      req_wstrb = '0;
      wbuf_pop  = 1'b0;

      case (state)
         ch_xfer: begin
            req       = ~wbuf_empty;
            req_wstrb = head_wstrb;
            wbuf_pop  = ack; // entry leaves in its ack cycle
         end
         default: ;
      endcase
   end

endmodule
